//--- hdl/uart_line_pkg.sv
`default_nettype none

package uart_line_pkg;

	// Receiver FSM
	typedef enum logic [1:0] {
		rx_idle,
		rx_start,   // waiting for mid start bit
		rx_data,
		rx_stop
	} rx_state_e;

	// Transmitter FSM
	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop
	} tx_state_e;

	// One byte with a single cycle strobe
	typedef struct packed {
		logic [7:0] data;
		logic       ok;
	} line_byte_s;

endpackage

`default_nettype wire

//--- hdl/uart_host_pkg.sv
`default_nettype none

package uart_host_pkg;

	// Host to controller
	typedef struct packed {
		logic [7:0] in_data;
		logic       in_valid;   // held until in_ready
		logic       out_valid;  // held while reading
	} host_req_s;

	// Controller to host
	typedef struct packed {
		logic       in_ready;   // one cycle pulse per accepted byte
		logic [7:0] out_data;
		logic       out_ready;  // out_data valid in this cycle
	} host_rsp_s;

endpackage

`default_nettype wire

//--- hdl/uart_rx.sv
`default_nettype none

module uart_rx import uart_line_pkg::*; #(
	parameter integer CLKS_PER_BIT = 16
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       rxd,
	output line_byte_s rx_byte
);

	localparam integer CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

	logic rxd_meta, rxd_sync;
	rx_state_e state;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic byte_ok;
	logic bit_end, half_end;

	assign bit_end = (cnt == BIT_LAST);
	assign half_end = (cnt == HALF_LAST);

	// Two flop synchronizer, line idles high
	always_ff @(posedge clk) begin
		if (reset) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rx_idle;
			cnt <= '0;
			bit_idx <= '0;
			byte_ok <= 1'b0;
		end else begin
			byte_ok <= 1'b0;
			case (state)
				rx_idle: begin
					cnt <= '0;
					if (!rxd_sync)
						state <= rx_start;
				end
				rx_start: begin
					if (half_end) begin
						cnt <= '0;
						bit_idx <= '0;
						state <= rxd_sync ? rx_idle : rx_data;  // glitch if high again
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				rx_data: begin
					if (bit_end) begin
						cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= rx_stop;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				rx_stop: begin
					if (bit_end) begin
						cnt <= '0;
						byte_ok <= rxd_sync;  // bad stop bit drops the frame
						state <= rx_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// LSB first
	always_ff @(posedge clk) begin
		if (state == rx_data && bit_end)
			shift <= {rxd_sync, shift[7:1]};
	end

	assign rx_byte = '{data: shift, ok: byte_ok};

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`default_nettype none

module uart_tx import uart_line_pkg::*; #(
	parameter integer CLKS_PER_BIT = 16
) (
	input  logic       clk,
	input  logic       reset,
	input  line_byte_s tx_cmd,
	output logic       tx_busy,
	output logic       txd
);

	localparam integer CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

	tx_state_e state;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic bit_end;

	assign bit_end = (cnt == BIT_LAST);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= tx_idle;
			cnt <= '0;
			bit_idx <= '0;
			tx_busy <= 1'b0;
			txd <= 1'b1;
		end else begin
			if (state == tx_idle) begin
				cnt <= '0;
				if (tx_cmd.ok) begin
					state <= tx_start;
					tx_busy <= 1'b1;
					txd <= 1'b0;  // start bit
				end
			end else if (!bit_end) begin
				cnt <= cnt + 1'b1;
			end else begin
				cnt <= '0;
				case (state)
					tx_start: begin
						state <= tx_data;
						bit_idx <= '0;
						txd <= shift[0];
					end
					tx_data: begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= tx_stop;
							txd <= 1'b1;
						end else begin
							txd <= shift[1];  // next bit after the shift below
						end
					end
					default: begin  // end of stop bit
						state <= tx_idle;
						tx_busy <= 1'b0;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == tx_idle && tx_cmd.ok)
			shift <= tx_cmd.data;
		else if (state == tx_data && bit_end)
			shift <= {1'b0, shift[7:1]};
	end

endmodule

`default_nettype wire

//--- hdl/uart_controller.sv
`default_nettype none

module uart_controller import uart_line_pkg::*, uart_host_pkg::*; #(
	parameter integer BUFFER_BIT_WIDTH = 4
) (
	input  logic                        clk,
	input  logic                        reset,
	input  host_req_s                   host_req,
	output host_rsp_s                   host_rsp,
	input  line_byte_s                  rx_byte,
	output line_byte_s                  tx_cmd,
	input  logic                        tx_busy,
	output logic                        lost,
	output logic [BUFFER_BIT_WIDTH-1:0] in_buffer_length
);

	localparam integer DEPTH = 2 ** BUFFER_BIT_WIDTH;

	logic [7:0] recv_buffer [DEPTH];
	logic [7:0] trans_buffer [DEPTH];
	logic [BUFFER_BIT_WIDTH-1:0] recv_head, recv_tail;
	logic [BUFFER_BIT_WIDTH-1:0] trans_head, trans_tail;
	logic [BUFFER_BIT_WIDTH-1:0] recv_head_next, recv_tail_next;
	logic [BUFFER_BIT_WIDTH-1:0] trans_head_next, trans_tail_next;

	logic recv_empty, recv_full;
	logic trans_empty, trans_full;
	logic recv_push, recv_pop, trans_push, trans_pop;

	logic in_ready, out_ready, trans_ok;
	logic [7:0] out_data, trans_data;

	// Pointer arithmetic kept at buffer width so wrap works
	always_comb begin
		recv_head_next = recv_head + 1'b1;
		recv_tail_next = recv_tail + 1'b1;
		trans_head_next = trans_head + 1'b1;
		trans_tail_next = trans_tail + 1'b1;
	end

	// One slot always left empty
	assign recv_empty = (recv_head == recv_tail);
	assign recv_full = (recv_tail_next == recv_head);
	assign trans_empty = (trans_head == trans_tail);
	assign trans_full = (trans_tail_next == trans_head);
	assign in_buffer_length = recv_tail - recv_head;

	assign recv_push = rx_byte.ok && !recv_full;
	assign recv_pop = host_req.out_valid && !out_ready && !recv_empty;
	assign trans_push = host_req.in_valid && !in_ready && !trans_full;
	assign trans_pop = !tx_busy && !trans_ok && !trans_empty;  // tx_busy lags trans_ok by a cycle

	// Receive side
	always_ff @(posedge clk) begin
		if (reset) begin
			recv_head <= '0;
			recv_tail <= '0;
			out_ready <= 1'b0;
			lost <= 1'b0;
		end else begin
			if (recv_push)
				recv_tail <= recv_tail_next;
			else if (rx_byte.ok)
				lost <= 1'b1;  // sticky until reset
			if (recv_pop)
				recv_head <= recv_head_next;
			out_ready <= recv_pop;
		end
	end

	always_ff @(posedge clk) begin
		if (recv_push)
			recv_buffer[recv_tail] <= rx_byte.data;
		if (recv_pop)
			out_data <= recv_buffer[recv_head];
	end

	// Transmit side
	always_ff @(posedge clk) begin
		if (reset) begin
			trans_head <= '0;
			trans_tail <= '0;
			in_ready <= 1'b0;
			trans_ok <= 1'b0;
		end else begin
			if (trans_push)
				trans_tail <= trans_tail_next;
			if (trans_pop)
				trans_head <= trans_head_next;
			in_ready <= trans_push;
			trans_ok <= trans_pop;
		end
	end

	always_ff @(posedge clk) begin
		if (trans_push)
			trans_buffer[trans_tail] <= host_req.in_data;
		if (trans_pop)
			trans_data <= trans_buffer[trans_head];
	end

	assign host_rsp = '{in_ready: in_ready, out_data: out_data, out_ready: out_ready};
	assign tx_cmd = '{data: trans_data, ok: trans_ok};

endmodule

`default_nettype wire

//--- hdl/uart_top.sv
`default_nettype none

module uart_top import uart_line_pkg::*, uart_host_pkg::*; #(
	parameter integer CLKS_PER_BIT     = 16,
	parameter integer BUFFER_BIT_WIDTH = 4
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        rxd,
	output logic                        txd,
	input  host_req_s                   host_req,
	output host_rsp_s                   host_rsp,
	output logic                        lost,
	output logic [BUFFER_BIT_WIDTH-1:0] in_buffer_length
);

	line_byte_s rx_byte;
	line_byte_s tx_cmd;
	logic tx_busy;

	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) i_rx (
		.clk(clk),
		.reset(reset),
		.rxd(rxd),
		.rx_byte(rx_byte)
	);

	uart_tx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) i_tx (
		.clk(clk),
		.reset(reset),
		.tx_cmd(tx_cmd),
		.tx_busy(tx_busy),
		.txd(txd)
	);

	// Buffers between host and line
	uart_controller #(
		.BUFFER_BIT_WIDTH(BUFFER_BIT_WIDTH)
	) i_ctrl (
		.clk(clk),
		.reset(reset),
		.host_req(host_req),
		.host_rsp(host_rsp),
		.rx_byte(rx_byte),
		.tx_cmd(tx_cmd),
		.tx_busy(tx_busy),
		.lost(lost),
		.in_buffer_length(in_buffer_length)
	);

endmodule

`default_nettype wire

//--- verif/uart_properties.sv
`default_nettype none

module uart_ctrl_properties (
	input logic clk,
	input logic reset,
	input logic in_ready,
	input logic out_ready,
	input logic trans_ok,
	input logic tx_busy,
	input logic lost
);

	timeunit 1ns;
	timeprecision 1ps;

	in_ready_single: assert property (@(posedge clk) disable iff (reset)
		in_ready |=> !in_ready)
		else $error("in_ready high two cycles in a row");

	out_ready_single: assert property (@(posedge clk) disable iff (reset)
		out_ready |=> !out_ready)
		else $error("out_ready high two cycles in a row");

	// Only reset clears it
	lost_sticky: assert property (@(posedge clk) disable iff (reset)
		lost |=> lost)
		else $error("lost fell without reset");

	trans_ok_when_idle: assert property (@(posedge clk) disable iff (reset)
		!(trans_ok && tx_busy))
		else $error("trans_ok fired while the transmitter was busy");

endmodule

bind uart_controller uart_ctrl_properties i_props (
	.clk(clk),
	.reset(reset),
	.in_ready(in_ready),
	.out_ready(out_ready),
	.trans_ok(trans_ok),
	.tx_busy(tx_busy),
	.lost(lost)
);

`default_nettype wire

//--- verif/uart_tb.sv
`default_nettype none

module uart_tb import uart_host_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam integer CLKS_PER_BIT = 16;
	localparam integer BUFFER_BIT_WIDTH = 3;
	localparam integer BUF_BYTES = 2 ** BUFFER_BIT_WIDTH - 1;
	localparam integer CLK_PERIOD = 40;
	localparam integer TOTAL_FRAMES = 20 + 6 + 9 + 3;
	localparam integer WATCHDOG_CYCLES = TOTAL_FRAMES * 10 * CLKS_PER_BIT + 3000;

	logic clk;
	logic reset;
	logic rxd;
	logic txd;
	host_req_s host_req;
	host_rsp_s host_rsp;
	logic lost;
	logic [BUFFER_BIT_WIDTH-1:0] in_buffer_length;

	logic [7:0] tx_expect [$];  // accepted but not yet seen on txd
	logic [7:0] rx_model [$];
	logic lost_model;
	integer errors;
	integer tests_run;
	integer tests_failed;
	integer test_start_errors;
	integer tx_frames;

	uart_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.BUFFER_BIT_WIDTH(BUFFER_BIT_WIDTH)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.rxd(rxd),
		.txd(txd),
		.host_req(host_req),
		.host_rsp(host_rsp),
		.lost(lost),
		.in_buffer_length(in_buffer_length)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("Regression failed");
		$finish;
	end

	// Inputs change and outputs are read 2 ns after the edge
	task automatic step(input integer n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic check_value(input string name, input integer got, input integer expected);
		if (got !== expected) begin
			$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic report_error(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != test_start_errors) begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, errors - test_start_errors);
		end else begin
			$display("test %s: ok", name);
		end
		test_start_errors = errors;
	endtask

	task automatic check_idle_outputs();
		check_value("in_ready", host_rsp.in_ready, 0);
		check_value("out_ready", host_rsp.out_ready, 0);
		check_value("lost", lost, 0);
		check_value("in_buffer_length", in_buffer_length, 0);
		check_value("txd", txd, 1);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		host_req = '0;
		rxd = 1'b1;
		repeat (8) begin
			step(1);
			check_idle_outputs();
		end
		reset = 1'b0;
		lost_model = 1'b0;
		rx_model.delete();
	endtask

	task automatic check_rx_status();
		check_value("in_buffer_length", in_buffer_length, rx_model.size());
		check_value("lost", lost, lost_model);
	endtask

	// 8N1 frame sent LSB first
	task automatic send_frame(input logic [7:0] data, input logic stop_bit);
		logic [9:0] bits;
		bits = {stop_bit, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rxd = bits[i];
			step(CLKS_PER_BIT);
		end
		rxd = 1'b1;
	endtask

	task automatic rx_good_frame(input logic [7:0] data);
		send_frame(data, 1'b1);
		if (rx_model.size() < BUF_BYTES)
			rx_model.push_back(data);
		else
			lost_model = 1'b1;
		step(2);
		check_rx_status();
	endtask

	task automatic write_byte(input logic [7:0] data, output integer waited);
		host_req.in_data = data;
		host_req.in_valid = 1'b1;
		waited = 0;
		step(1);
		while (!host_rsp.in_ready && waited < 40 * CLKS_PER_BIT) begin
			step(1);
			waited++;
		end
		host_req.in_valid = 1'b0;
		if (host_rsp.in_ready) begin
			tx_expect.push_back(data);
			if (tx_expect.size() > BUF_BYTES + 1)  // buffer plus one frame in flight
				report_error("byte accepted while the transmit buffer was full");
		end else begin
			report_error("in_ready never came for a host write");
		end
	endtask

	task automatic read_byte();
		integer waited;
		logic [7:0] expected;
		host_req.out_valid = 1'b1;
		waited = 0;
		step(1);
		while (!host_rsp.out_ready && waited < 20) begin
			step(1);
			waited++;
		end
		host_req.out_valid = 1'b0;
		if (!host_rsp.out_ready) begin
			report_error("out_ready never came for a host read");
		end else if (rx_model.size() == 0) begin
			report_error("read returned data although the model buffer is empty");
		end else begin
			expected = rx_model.pop_front();
			check_value("out_data", host_rsp.out_data, expected);
		end
	endtask

	// Decodes txd and checks that each bit holds for a full bit period
	initial begin : txd_monitor
		logic [9:0] bits;
		logic level;
		logic steady;
		tx_frames = 0;
		forever begin
			@(negedge txd);
			steady = 1'b1;
			for (int b = 0; b < 10; b++) begin
				@(negedge clk);
				level = txd;
				for (int c = 1; c < CLKS_PER_BIT; c++) begin
					@(negedge clk);
					if (c == CLKS_PER_BIT / 2)
						bits[b] = txd;
					if (txd != level)
						steady = 1'b0;
				end
			end
			if (!steady)
				report_error("a bit on txd did not last one bit period");
			if (bits[0] != 1'b0)
				report_error("start bit on txd not low at mid-bit");
			if (bits[9] != 1'b1)
				report_error("stop bit on txd not high");
			if (tx_expect.size() == 0)
				report_error("unexpected frame on txd");
			else
				check_value("txd byte", bits[8:1], tx_expect.pop_front());
			tx_frames++;
		end
	end

	initial begin
		integer waited;
		integer held_off;
		logic [7:0] data;
		void'($urandom(83362));
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_start_errors = 0;
		lost_model = 1'b0;
		reset = 1'b1;
		rxd = 1'b1;
		host_req = '0;

		apply_reset();
		for (int i = 0; i < 4; i++) begin
			step(1);
			check_idle_outputs();
		end
		finish_test("reset");

		held_off = 0;
		for (int i = 0; i < 20; i++) begin
			write_byte(8'($urandom_range(255, 0)), waited);
			if (waited > 2 * CLKS_PER_BIT)
				held_off++;
		end
		waited = 0;
		while (tx_expect.size() != 0 && waited < 20 * 10 * CLKS_PER_BIT) begin
			step(1);
			waited++;
		end
		if (tx_expect.size() != 0)
			report_error("written bytes never all appeared on txd");
		if (held_off == 0)
			report_error("host writes were never held off by a full transmit buffer");
		check_value("frames on txd", tx_frames, 20);
		finish_test("transmit");

		for (int i = 0; i < 6; i++)
			rx_good_frame(8'($urandom_range(255, 0)));
		for (int i = 0; i < 6; i++)
			read_byte();
		check_rx_status();
		finish_test("receive");

		host_req.out_valid = 1'b1;
		for (int i = 0; i < 40; i++) begin
			step(1);
			check_value("out_ready", host_rsp.out_ready, 0);
		end
		host_req.out_valid = 1'b0;
		finish_test("empty read");

		for (int i = 0; i < 9; i++) begin
			rx_good_frame(8'($urandom_range(255, 0)));
			if (i == 7)
				check_value("lost", lost, 1);
		end
		check_value("in_buffer_length", in_buffer_length, BUF_BYTES);
		for (int i = 0; i < BUF_BYTES; i++)
			read_byte();
		check_value("lost", lost, 1);  // still set after draining
		apply_reset();
		step(1);
		check_value("lost", lost, 0);
		finish_test("overflow");

		rx_good_frame(8'($urandom_range(255, 0)));
		data = 8'($urandom_range(255, 0));
		send_frame(data, 1'b0);
		step(2 * CLKS_PER_BIT);
		check_rx_status();
		rx_good_frame(8'($urandom_range(255, 0)));
		check_value("in_buffer_length", in_buffer_length, 2);
		read_byte();
		read_byte();
		finish_test("framing error");

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
hdl/uart_line_pkg.sv
hdl/uart_host_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_controller.sv
hdl/uart_top.sv
verif/uart_properties.sv
verif/uart_tb.sv

//--- Bender.yml
package:
  name: uart_subsystem

sources:
  - files:
      - hdl/uart_line_pkg.sv
      - hdl/uart_host_pkg.sv
      - hdl/uart_rx.sv
      - hdl/uart_tx.sv
      - hdl/uart_controller.sv
      - hdl/uart_top.sv
  - target: simulation
    files:
      - verif/uart_properties.sv
      - verif/uart_tb.sv
